// ==== verilog/jtframe_dwnld_pkg.sv ====
`default_nettype none

package jtframe_dwnld_pkg;

    // HPS download bus
    localparam int HPS_AW   = 27;
    localparam int HPS_IDXW = 8;

    // Index codes sent by the HPS with each file
    localparam logic [HPS_IDXW-1:0] ROM_INDEX = 8'd0;
    localparam logic [HPS_IDXW-1:0] DIP_INDEX = 8'd254;

    // SDRAM programming port
    localparam int PROG_DW = 16;
    localparam int PROG_MW = 2;

    localparam int DIPSW_W = 32;

endpackage

`default_nettype wire

// ==== verilog/jtframe_dwnld_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module jtframe_dwnld_fifo #(
    parameter AW      = 24,
    parameter FIFO_AW = 3
)(
    input  logic          clk_rom,
    input  logic          rst,

    input  logic          push,
    input  logic [AW-1:0] push_addr,
    input  logic [7:0]    push_data,
    output logic          full,

    input  logic          pop,
    output logic          empty,
    output logic [AW-1:0] pop_addr,
    output logic [7:0]    pop_data
);

    localparam int DEPTH = 1 << FIFO_AW;

    logic [AW+7:0]      mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    assign full  = count == (FIFO_AW+1)'(DEPTH);
    assign empty = count == '0;

    // Head entry is always visible
    assign {pop_addr, pop_data} = mem[rd_ptr];

    always_ff @(posedge clk_rom) begin
        if (push) begin
            mem[wr_ptr] <= {push_addr, push_data};
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'd1;
            if (pop)  rd_ptr <= rd_ptr + 1'd1;
            case ({push, pop})
                2'b10:   count <= count + 1'd1;
                2'b01:   count <= count - 1'd1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk_rom) disable iff (rst)
        push |-> !full
    ) else $error("push into a full FIFO");

    a_no_underflow: assert property (
        @(posedge clk_rom) disable iff (rst)
        pop |-> !empty
    ) else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// ==== verilog/jtframe_dwnld_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module jtframe_dwnld_rx
    import jtframe_dwnld_pkg::*;
#(
    parameter SDRAMW = 23
)(
    input  logic                clk_rom,
    input  logic                rst,

    // HPS byte stream
    input  logic                hps_download,
    input  logic [HPS_IDXW-1:0] hps_index,
    input  logic                hps_wr,
    input  logic [HPS_AW-1:0]   hps_addr,
    input  logic [7:0]          hps_dout,
    output logic                hps_wait,

    // FIFO write side
    input  logic                full,
    output logic                push,
    output logic [SDRAMW:0]     push_addr,
    output logic [7:0]          push_data,

    output logic                rom_load,
    output logic [DIPSW_W-1:0]  dipsw
);

    logic dip_load;

    assign rom_load = hps_download && (hps_index == ROM_INDEX);
    assign dip_load = hps_download && (hps_index == DIP_INDEX);

    // The HPS holds off while there is no room for another ROM byte
    assign hps_wait = full;

    // ROM bytes go straight to the buffer in the strobe cycle
    assign push      = hps_wr && rom_load;
    assign push_addr = hps_addr[SDRAMW:0];
    assign push_data = hps_dout;

    // DIP word, one byte lane per address
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            dipsw <= '0;
        end else if (hps_wr && dip_load) begin
            dipsw[{hps_addr[1:0], 3'b000} +: 8] <= hps_dout;
        end
    end

    // Strobes are only legal while the buffer has room
    a_no_wr_on_wait: assert property (
        @(posedge clk_rom) disable iff (rst)
        hps_wait |-> !hps_wr
    ) else $error("hps_wr issued while hps_wait is high");

endmodule

`default_nettype wire

// ==== verilog/jtframe_prog_wr.sv ====
`timescale 1ns/10ps
`default_nettype none

module jtframe_prog_wr
    import jtframe_dwnld_pkg::*;
#(
    parameter SDRAMW = 23
)(
    input  logic               clk_rom,
    input  logic               rst,
    input  logic               rom_load,

    // FIFO read side
    input  logic               empty,
    input  logic [SDRAMW:0]    pop_addr,
    input  logic [7:0]         pop_data,
    output logic               pop,

    // SDRAM programming port
    output logic               prog_we,
    output logic [SDRAMW-1:0]  prog_addr,
    output logic [PROG_DW-1:0] prog_data,
    output logic [PROG_MW-1:0] prog_mask,
    input  logic               prog_rdy,

    output logic               downloading
);

    logic busy;

    // A write is still waiting for its ready
    assign busy = prog_we && !prog_rdy;

    // Load the next entry when idle or as the current write completes
    assign pop = !empty && !busy;

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            prog_we <= 1'b0;
        end else if (pop) begin
            prog_we <= 1'b1;
        end else if (prog_rdy) begin
            prog_we <= 1'b0;
        end
    end

    // Word address, byte on both lanes, active low lane mask
    always_ff @(posedge clk_rom) begin
        if (pop) begin
            prog_addr <= pop_addr[SDRAMW:1];
            prog_data <= {pop_data, pop_data};
            prog_mask <= pop_addr[0] ? 2'b01 : 2'b10;
        end
    end

    // Stays up until the last buffered byte has been written
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            downloading <= 1'b0;
        end else begin
            downloading <= rom_load || (downloading && (!empty || busy));
        end
    end

    a_prog_stable: assert property (
        @(posedge clk_rom) disable iff (rst)
        busy |=> $stable(prog_addr) && $stable(prog_data) && $stable(prog_mask)
    ) else $error("programming port changed before prog_rdy");

endmodule

`default_nettype wire

// ==== verilog/jtframe_mister_dwnld.sv ====
`timescale 1ns/10ps
`default_nettype none

module jtframe_mister_dwnld
    import jtframe_dwnld_pkg::*;
#(
    parameter SDRAMW  = 23,
    parameter FIFO_AW = 3
)(
    input  logic                clk_rom,
    input  logic                rst,

    // HPS download
    input  logic                hps_download,
    input  logic [HPS_IDXW-1:0] hps_index,
    input  logic                hps_wr,
    input  logic [HPS_AW-1:0]   hps_addr,
    input  logic [7:0]          hps_dout,
    output logic                hps_wait,

    output logic [DIPSW_W-1:0]  dipsw,

    // ROM programming
    output logic                prog_we,
    output logic [SDRAMW-1:0]   prog_addr,
    output logic [PROG_DW-1:0]  prog_data,
    output logic [PROG_MW-1:0]  prog_mask,
    input  logic                prog_rdy,
    output logic                downloading
);

    logic            push, pop, full, empty, rom_load;
    logic [SDRAMW:0] push_addr, pop_addr;
    logic [7:0]      push_data, pop_data;

    jtframe_dwnld_rx #(.SDRAMW(SDRAMW)) u_rx(
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .hps_download   ( hps_download   ),
        .hps_index      ( hps_index      ),
        .hps_wr         ( hps_wr         ),
        .hps_addr       ( hps_addr       ),
        .hps_dout       ( hps_dout       ),
        .hps_wait       ( hps_wait       ),
        .full           ( full           ),
        .push           ( push           ),
        .push_addr      ( push_addr      ),
        .push_data      ( push_data      ),
        .rom_load       ( rom_load       ),
        .dipsw          ( dipsw          )
    );

    // Byte addresses carry one bit more than the SDRAM word address
    jtframe_dwnld_fifo #(
        .AW         ( SDRAMW+1  ),
        .FIFO_AW    ( FIFO_AW   )
    ) u_fifo(
        .clk_rom    ( clk_rom   ),
        .rst        ( rst       ),
        .push       ( push      ),
        .push_addr  ( push_addr ),
        .push_data  ( push_data ),
        .full       ( full      ),
        .pop        ( pop       ),
        .empty      ( empty     ),
        .pop_addr   ( pop_addr  ),
        .pop_data   ( pop_data  )
    );

    jtframe_prog_wr #(.SDRAMW(SDRAMW)) u_prog(
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .rom_load       ( rom_load       ),
        .empty          ( empty          ),
        .pop_addr       ( pop_addr       ),
        .pop_data       ( pop_data       ),
        .pop            ( pop            ),
        .prog_we        ( prog_we        ),
        .prog_addr      ( prog_addr      ),
        .prog_data      ( prog_data      ),
        .prog_mask      ( prog_mask      ),
        .prog_rdy       ( prog_rdy       ),
        .downloading    ( downloading    )
    );

endmodule

`default_nettype wire

// ==== dv/tb_dwnld_table.svh ====
`ifndef TB_DWNLD_TABLE_SVH
`define TB_DWNLD_TABLE_SVH

// One HPS byte per row
// test | index | byte address | byte | idle cycles after | dipsw expected after the row
typedef struct packed {
    logic [3:0]  test;
    logic [7:0]  index;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  gap;
    logic [31:0] dip_exp;
} row_t;

localparam int NUM_ROWS = 26;

localparam row_t STIM [NUM_ROWS] = '{
    // ROM load, mixed gaps and lanes
    {4'd2, ROM_INDEX, 16'h0000, 8'h3c, 8'd2, 32'h0000_0000},
    {4'd2, ROM_INDEX, 16'h0001, 8'hc5, 8'd0, 32'h0000_0000},
    {4'd2, ROM_INDEX, 16'h0002, 8'h71, 8'd3, 32'h0000_0000},
    {4'd2, ROM_INDEX, 16'h0081, 8'h0e, 8'd1, 32'h0000_0000},
    {4'd2, ROM_INDEX, 16'h0080, 8'hd2, 8'd0, 32'h0000_0000},
    {4'd2, ROM_INDEX, 16'h0003, 8'h9a, 8'd4, 32'h0000_0000},
    // DIP lanes, other indexes leave everything alone
    {4'd3, DIP_INDEX, 16'h0000, 8'h12, 8'd1, 32'h0000_0012},
    {4'd3, DIP_INDEX, 16'h0002, 8'hab, 8'd1, 32'h00ab_0012},
    {4'd3, 8'd1,      16'h0004, 8'h55, 8'd1, 32'h00ab_0012},
    {4'd3, DIP_INDEX, 16'h0003, 8'h80, 8'd0, 32'h80ab_0012},
    {4'd3, DIP_INDEX, 16'h0005, 8'h34, 8'd2, 32'h80ab_3412},
    {4'd3, 8'd253,    16'h0000, 8'h77, 8'd1, 32'h80ab_3412},
    // Burst against the slowest SDRAM
    {4'd4, ROM_INDEX, 16'h0020, 8'ha0, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0021, 8'h1b, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0022, 8'hc4, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0023, 8'h5d, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0024, 8'he6, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0025, 8'h07, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0026, 8'hf8, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0027, 8'h69, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0028, 8'h3a, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h0029, 8'h8b, 8'd0, 32'h80ab_3412},
    {4'd4, ROM_INDEX, 16'h002a, 8'h9c, 8'd0, 32'h80ab_3412},
    // Download ends while writes are still queued
    {4'd5, ROM_INDEX, 16'h0041, 8'h5e, 8'd0, 32'h80ab_3412},
    {4'd5, ROM_INDEX, 16'h0040, 8'he1, 8'd0, 32'h80ab_3412},
    {4'd5, ROM_INDEX, 16'h0042, 8'h2d, 8'd0, 32'h80ab_3412}
};

`endif

// ==== dv/tb_jtframe_mister_dwnld.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_jtframe_mister_dwnld
    import jtframe_dwnld_pkg::*;
();

    localparam int SDRAMW  = 23;
    localparam int FIFO_AW = 3;
    localparam int EXP_W   = SDRAMW + PROG_DW + PROG_MW;

    logic                clk_rom = 1'b0;
    logic                rst;
    logic                hps_download;
    logic [HPS_IDXW-1:0] hps_index;
    logic                hps_wr;
    logic [HPS_AW-1:0]   hps_addr;
    logic [7:0]          hps_dout;
    logic                hps_wait;
    logic [DIPSW_W-1:0]  dipsw;
    logic                prog_we;
    logic [SDRAMW-1:0]   prog_addr;
    logic [PROG_DW-1:0]  prog_data;
    logic [PROG_MW-1:0]  prog_mask;
    logic                prog_rdy = 1'b0;
    logic                downloading;

    `include "tb_dwnld_table.svh"

    // Writes still owed by the DUT in issue order
    logic [EXP_W-1:0] exp_q [$];
    logic [7:0]       model_mem [256];
    logic             rdy_armed = 1'b0;
    logic             slow_sdram = 1'b0;
    int seed = 32'h4396_3532;
    int rdy_wait = 0;
    int write_count = 0, exp_total = 0, err_count = 0, test_err_base = 0;
    int wait_seen = 0, tests_passed = 0, tests_failed = 0;
    int cycles = 0, cycle_limit = 0;

    always #10 clk_rom = ~clk_rom;

    jtframe_mister_dwnld #(.SDRAMW(SDRAMW), .FIFO_AW(FIFO_AW)) u_jtframe_mister_dwnld(
        .clk_rom(clk_rom), .rst(rst), .hps_download(hps_download), .hps_index(hps_index),
        .hps_wr(hps_wr), .hps_addr(hps_addr), .hps_dout(hps_dout), .hps_wait(hps_wait),
        .dipsw(dipsw), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_rdy(prog_rdy), .downloading(downloading)
    );

    // SDRAM model answers each write with one ready pulse after 0 to 7 cycles
    always @(negedge clk_rom) begin
        if (rst) begin
            prog_rdy = 1'b0;
            rdy_armed = 1'b0;
        end else begin
            prog_rdy = 1'b0;
            if (prog_we) begin
                if (!rdy_armed) begin
                    rdy_wait = slow_sdram ? 7 : ($random(seed) & 7);
                    rdy_armed = 1'b1;
                end
                if (rdy_wait == 0) begin
                    prog_rdy = 1'b1;
                    rdy_armed = 1'b0;
                end else begin
                    rdy_wait--;
                end
            end
        end
    end

    // Completed writes are sampled with the values held before the edge
    always @(posedge clk_rom) begin
        if (!rst && prog_we && prog_rdy) begin
            write_count++;
            if (!prog_mask[0]) model_mem[{prog_addr[6:0], 1'b0}] = prog_data[7:0];
            if (!prog_mask[1]) model_mem[{prog_addr[6:0], 1'b1}] = prog_data[15:8];
            $display("%0t write addr %h data %h mask %b", $time, prog_addr, prog_data, prog_mask);
            assert (exp_q.size() > 0 && {prog_addr, prog_data, prog_mask} == exp_q[0]) else begin
                $display("Error: %0t write %h %h %b does not match the next expected write",
                         $time, prog_addr, prog_data, prog_mask);
                err_count++;
            end
            if (exp_q.size() > 0) exp_q.pop_front();
        end
    end

    always @(negedge clk_rom) begin
        if (!rst) begin
            assert (!prog_we || downloading) else begin
                $display("Error: %0t prog_we high while downloading is low", $time);
                err_count++;
            end
        end
    end

    always @(posedge clk_rom) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int timeout_limit();
        int total;
        total = 200;
        for (int i = 0; i < NUM_ROWS; i++) total += int'(STIM[i].gap) + 12;
        return total;
    endfunction

    function automatic string test_name(input logic [3:0] t);
        case (t)
            4'd1:    return "reset state";
            4'd2:    return "ROM load";
            4'd3:    return "DIP bytes";
            4'd4:    return "back-pressure";
            default: return "download flag";
        endcase
    endfunction

    task automatic report_test(input logic [3:0] t);
        if (err_count == test_err_base) begin
            tests_passed++;
            $display("Test %0d %s: passed", t, test_name(t));
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", t, test_name(t), err_count - test_err_base);
        end
        test_err_base = err_count;
        wait_seen = 0;
    endtask

    // Waits for room, strobes one byte and records what it must cause
    task automatic send_byte(input row_t r);
        logic [PROG_MW-1:0] exp_mask;
        while (hps_wait) begin
            wait_seen++;
            @(negedge clk_rom);
        end
        hps_index = r.index;
        hps_addr = HPS_AW'(r.addr);
        hps_dout = r.data;
        hps_wr = 1'b1;
        if (r.index == ROM_INDEX) begin
            exp_mask = 2'b11;
            exp_mask[r.addr[0]] = 1'b0;
            exp_q.push_back({SDRAMW'(r.addr >> 1), r.data, r.data, exp_mask});
            exp_total++;
        end
        @(negedge clk_rom);
        hps_wr = 1'b0;
        assert (dipsw == r.dip_exp) else begin
            $display("Error: %0t dipsw %h, expected %h", $time, dipsw, r.dip_exp);
            err_count++;
        end
        repeat (int'(r.gap)) @(negedge clk_rom);
    endtask

    task automatic finish_test(input logic [3:0] t);
        if (t == 4'd5) begin
            hps_download = 1'b0;
            // The DUT has now seen the download end with writes still queued
            @(negedge clk_rom);
            assert (downloading) else begin
                $display("Error: %0t downloading low while ROM writes remain", $time);
                err_count++;
            end
            while (downloading) @(negedge clk_rom);
            assert (write_count == exp_total && !prog_we) else begin
                $display("Error: %0t downloading fell after %0d of %0d writes",
                         $time, write_count, exp_total);
                err_count++;
            end
            repeat (12) begin
                @(negedge clk_rom);
                assert (!prog_we) else begin
                    $display("Error: %0t write started after downloading fell", $time);
                    err_count++;
                end
            end
        end
        while (write_count < exp_total) @(negedge clk_rom);
        repeat (10) @(negedge clk_rom);
        assert (write_count == exp_total) else begin
            $display("Error: %0t %0d writes seen, expected %0d", $time, write_count, exp_total);
            err_count++;
        end
        if (t == 4'd4) begin
            assert (wait_seen > 0) else begin
                $display("The burst never saw hps_wait high, so back-pressure went untested");
                err_count++;
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (STIM[i].test == t && STIM[i].index == ROM_INDEX) begin
                assert (model_mem[STIM[i].addr[7:0]] == STIM[i].data) else begin
                    $display("Error: %0t memory at %h holds %h, expected %h", $time,
                             STIM[i].addr, model_mem[STIM[i].addr[7:0]], STIM[i].data);
                    err_count++;
                end
            end
        end
        report_test(t);
    endtask

    initial begin
        logic [3:0] prev;
        cycle_limit = timeout_limit();
        for (int i = 0; i < 256; i++) model_mem[i] = ~8'(i);
        rst = 1'b1;
        hps_download = 1'b0;
        hps_index = '0;
        hps_wr = 1'b0;
        hps_addr = '0;
        hps_dout = '0;
        repeat (10) @(posedge clk_rom);
        @(negedge clk_rom);
        rst = 1'b0;
        @(negedge clk_rom);
        assert (!prog_we && !hps_wait && !downloading && dipsw == '0) else begin
            $display("Error: %0t after reset prog_we %b hps_wait %b downloading %b dipsw %h",
                     $time, prog_we, hps_wait, downloading, dipsw);
            err_count++;
        end
        report_test(4'd1);

        hps_download = 1'b1;
        prev = STIM[0].test;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (STIM[i].test != prev) begin
                finish_test(prev);
                prev = STIM[i].test;
            end
            slow_sdram = STIM[i].test >= 4'd4;
            send_byte(STIM[i]);
        end
        finish_test(prev);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+dv
verilog/jtframe_dwnld_pkg.sv
verilog/jtframe_dwnld_fifo.sv
verilog/jtframe_dwnld_rx.sv
verilog/jtframe_prog_wr.sv
verilog/jtframe_mister_dwnld.sv
dv/tb_jtframe_mister_dwnld.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the download testbench with Verilator

TOP=tb_jtframe_mister_dwnld
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
    --top-module "$TOP" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
